// ==== logic/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
  input  logic               clk_i,
  input  logic               rst_ni,

  // Instruction strobe
  input  logic               instr_valid_i,
  input  rv_pkg::word_t      instr_i,

  // Retire port
  output logic               retire_valid_o,
  output rv_pkg::reg_addr_t  retire_rd_o,
  output rv_pkg::word_t      retire_data_o,
  output logic               retire_illegal_o
);

  // Decode to operand
  logic               dec_valid;
  rv_pkg::reg_addr_t  dec_rs1;
  rv_pkg::reg_addr_t  dec_rs2;
  rv_pkg::reg_addr_t  dec_rd;
  logic               dec_we;
  rv_pkg::alu_op_e    dec_alu_op;
  logic               dec_use_imm;
  rv_pkg::word_t      dec_imm;
  logic               dec_illegal;

  // Operand to execute
  logic               opd_valid;
  rv_pkg::word_t      opd_a;
  rv_pkg::word_t      opd_b;
  rv_pkg::reg_addr_t  opd_rd;
  logic               opd_we;
  rv_pkg::alu_op_e    opd_alu_op;
  logic               opd_illegal;

  // Execute back to operand
  rv_pkg::word_t      alu_result;
  logic               retire_we;

  rv_decode_stage decode_stage_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .dec_valid_o   (dec_valid),
    .dec_rs1_o     (dec_rs1),
    .dec_rs2_o     (dec_rs2),
    .dec_rd_o      (dec_rd),
    .dec_we_o      (dec_we),
    .dec_alu_op_o  (dec_alu_op),
    .dec_use_imm_o (dec_use_imm),
    .dec_imm_o     (dec_imm),
    .dec_illegal_o (dec_illegal)
  );

  rv_operand_stage operand_stage_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .dec_valid_i   (dec_valid),
    .dec_rs1_i     (dec_rs1),
    .dec_rs2_i     (dec_rs2),
    .dec_rd_i      (dec_rd),
    .dec_we_i      (dec_we),
    .dec_alu_op_i  (dec_alu_op),
    .dec_use_imm_i (dec_use_imm),
    .dec_imm_i     (dec_imm),
    .dec_illegal_i (dec_illegal),
    .ex_valid_i    (opd_valid),
    .ex_we_i       (opd_we),
    .ex_rd_i       (opd_rd),
    .ex_result_i   (alu_result),
    .wb_we_i       (retire_we),
    .wb_rd_i       (retire_rd_o),
    .wb_data_i     (retire_data_o),
    .opd_valid_o   (opd_valid),
    .opd_a_o       (opd_a),
    .opd_b_o       (opd_b),
    .opd_rd_o      (opd_rd),
    .opd_we_o      (opd_we),
    .opd_alu_op_o  (opd_alu_op),
    .opd_illegal_o (opd_illegal)
  );

  rv_execute_stage execute_stage_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .opd_valid_i      (opd_valid),
    .opd_a_i          (opd_a),
    .opd_b_i          (opd_b),
    .opd_rd_i         (opd_rd),
    .opd_we_i         (opd_we),
    .opd_alu_op_i     (opd_alu_op),
    .opd_illegal_i    (opd_illegal),
    .alu_result_o     (alu_result),
    .retire_valid_o   (retire_valid_o),
    .retire_rd_o      (retire_rd_o),
    .retire_data_o    (retire_data_o),
    .retire_we_o      (retire_we),
    .retire_illegal_o (retire_illegal_o)
  );

endmodule

// ==== logic/rv_decode_stage.sv ====
`timescale 1ns/1ps

module rv_decode_stage (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  logic               instr_valid_i,
  input  rv_pkg::word_t      instr_i,

  output logic               dec_valid_o,
  output rv_pkg::reg_addr_t  dec_rs1_o,
  output rv_pkg::reg_addr_t  dec_rs2_o,
  output rv_pkg::reg_addr_t  dec_rd_o,
  output logic               dec_we_o,
  output rv_pkg::alu_op_e    dec_alu_op_o,
  output logic               dec_use_imm_o,
  output rv_pkg::word_t      dec_imm_o,
  output logic               dec_illegal_o
);

  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  word_t      imm_i_type;
  word_t      imm_shamt;
  word_t      imm_u_type;
  logic       funct7_ok;

  alu_op_e    alu_op;
  logic       use_imm;
  word_t      imm;
  logic       illegal;

  // Field split
  assign opcode = opcode_e'(instr_i[6:0]);
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  assign imm_i_type = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_shamt  = {{(XLEN-5){1'b0}}, instr_i[24:20]};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  // 0x20 only allowed on the add/sub and right shift slots
  assign funct7_ok = (funct7 == F7_ZERO) ||
                     ((funct7 == F7_ALT) && ((funct3 == F3_ADD) || (funct3 == F3_SR)));

  function automatic alu_op_e funct_to_alu_op(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  ////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////

  always_comb begin
    alu_op  = funct_to_alu_op(funct3, funct7 == F7_ALT);
    use_imm = 1'b0;
    imm     = imm_i_type;
    illegal = 1'b0;
    case (opcode)
      OPC_OP: begin
        illegal = !funct7_ok;
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        if ((funct3 == F3_SLL) || (funct3 == F3_SR)) begin
          // Upper bits of the immediate act as funct7 for shifts
          imm     = imm_shamt;
          illegal = !funct7_ok;
        end else if ((funct3 == F3_ADD) && (funct7 == F7_ALT)) begin
          // No SUB-immediate
          illegal = 1'b1;
        end
      end
      OPC_LUI: begin
        alu_op  = ALU_PASS_B;
        use_imm = 1'b1;
        imm     = imm_u_type;
      end
      default: illegal = 1'b1;
    endcase
  end

  // Control flags, cleared on reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_o   <= 1'b0;
      dec_we_o      <= 1'b0;
      dec_illegal_o <= 1'b0;
    end else begin
      dec_valid_o   <= instr_valid_i;
      dec_we_o      <= instr_valid_i & ~illegal & (rd != '0);
      dec_illegal_o <= instr_valid_i & illegal;
    end
  end

  // Payload fields
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      dec_rs1_o     <= rs1;
      dec_rs2_o     <= rs2;
      dec_rd_o      <= rd;
      dec_alu_op_o  <= alu_op;
      dec_use_imm_o <= use_imm;
      dec_imm_o     <= imm;
    end
  end

endmodule

// ==== logic/rv_execute_stage.sv ====
`timescale 1ns/1ps

module rv_execute_stage (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  logic               opd_valid_i,
  input  rv_pkg::word_t      opd_a_i,
  input  rv_pkg::word_t      opd_b_i,
  input  rv_pkg::reg_addr_t  opd_rd_i,
  input  logic               opd_we_i,
  input  rv_pkg::alu_op_e    opd_alu_op_i,
  input  logic               opd_illegal_i,

  // Unregistered, for forwarding
  output rv_pkg::word_t      alu_result_o,

  output logic               retire_valid_o,
  output rv_pkg::reg_addr_t  retire_rd_o,
  output rv_pkg::word_t      retire_data_o,
  output logic               retire_we_o,
  output logic               retire_illegal_o
);

  import rv_pkg::*;

  logic [4:0] shamt;

  assign shamt = opd_b_i[4:0];

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (opd_alu_op_i)
      ALU_ADD:    alu_result_o = opd_a_i + opd_b_i;
      ALU_SUB:    alu_result_o = opd_a_i - opd_b_i;
      ALU_SLL:    alu_result_o = opd_a_i << shamt;
      ALU_SLT: begin
        alu_result_o = {{(XLEN-1){1'b0}}, $signed(opd_a_i) < $signed(opd_b_i)};
      end
      ALU_SLTU:   alu_result_o = {{(XLEN-1){1'b0}}, opd_a_i < opd_b_i};
      ALU_XOR:    alu_result_o = opd_a_i ^ opd_b_i;
      ALU_SRL:    alu_result_o = opd_a_i >> shamt;
      ALU_SRA:    alu_result_o = word_t'($signed(opd_a_i) >>> shamt);
      ALU_OR:     alu_result_o = opd_a_i | opd_b_i;
      ALU_AND:    alu_result_o = opd_a_i & opd_b_i;
      ALU_PASS_B: alu_result_o = opd_b_i;
      default:    alu_result_o = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Retire register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_valid_o   <= 1'b0;
      retire_we_o      <= 1'b0;
      retire_illegal_o <= 1'b0;
    end else begin
      retire_valid_o   <= opd_valid_i;
      retire_we_o      <= opd_we_i;
      retire_illegal_o <= opd_illegal_i;
    end
  end

  // Illegal instructions report zero
  always_ff @(posedge clk_i) begin
    if (opd_valid_i) begin
      retire_rd_o   <= opd_rd_i;
      retire_data_o <= opd_illegal_i ? '0 : alu_result_o;
    end
  end

endmodule

// ==== logic/rv_operand_stage.sv ====
`timescale 1ns/1ps

module rv_operand_stage (
  input  logic               clk_i,
  input  logic               rst_ni,

  // From decode
  input  logic               dec_valid_i,
  input  rv_pkg::reg_addr_t  dec_rs1_i,
  input  rv_pkg::reg_addr_t  dec_rs2_i,
  input  rv_pkg::reg_addr_t  dec_rd_i,
  input  logic               dec_we_i,
  input  rv_pkg::alu_op_e    dec_alu_op_i,
  input  logic               dec_use_imm_i,
  input  rv_pkg::word_t      dec_imm_i,
  input  logic               dec_illegal_i,

  // Instruction in execute
  input  logic               ex_valid_i,
  input  logic               ex_we_i,
  input  rv_pkg::reg_addr_t  ex_rd_i,
  input  rv_pkg::word_t      ex_result_i,

  // Retire register, also the write port
  input  logic               wb_we_i,
  input  rv_pkg::reg_addr_t  wb_rd_i,
  input  rv_pkg::word_t      wb_data_i,

  output logic               opd_valid_o,
  output rv_pkg::word_t      opd_a_o,
  output rv_pkg::word_t      opd_b_o,
  output rv_pkg::reg_addr_t  opd_rd_o,
  output logic               opd_we_o,
  output rv_pkg::alu_op_e    opd_alu_op_o,
  output logic               opd_illegal_o
);

  import rv_pkg::*;

  word_t rf_rdata_a;
  word_t rf_rdata_b;
  word_t rs1_value;
  word_t rs2_value;

  rv_regfile regfile_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (dec_rs1_i),
    .rdata_a_o (rf_rdata_a),
    .raddr_b_i (dec_rs2_i),
    .rdata_b_o (rf_rdata_b),
    .we_i      (wb_we_i),
    .waddr_i   (wb_rd_i),
    .wdata_i   (wb_data_i)
  );

  // Newest producer wins; x0 never forwards
  function automatic word_t pick_operand(input reg_addr_t rs, input word_t rf_data);
    word_t value;
    if (rs == '0) begin
      value = '0;
    end else if (ex_valid_i && ex_we_i && (ex_rd_i == rs)) begin
      value = ex_result_i;
    end else if (wb_we_i && (wb_rd_i == rs)) begin
      value = wb_data_i;
    end else begin
      value = rf_data;
    end
    return value;
  endfunction

  assign rs1_value = pick_operand(dec_rs1_i, rf_rdata_a);
  assign rs2_value = pick_operand(dec_rs2_i, rf_rdata_b);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      opd_valid_o   <= 1'b0;
      opd_we_o      <= 1'b0;
      opd_illegal_o <= 1'b0;
    end else begin
      opd_valid_o   <= dec_valid_i;
      opd_we_o      <= dec_we_i;
      opd_illegal_o <= dec_illegal_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      opd_a_o      <= rs1_value;
      opd_b_o      <= dec_use_imm_i ? dec_imm_i : rs2_value;
      opd_rd_o     <= dec_rd_i;
      opd_alu_op_o <= dec_alu_op_i;
    end
  end

endmodule

// ==== logic/rv_pkg.sv ====
package rv_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  ////////////////////////////////////////////////////////////
  // Instruction encodings
  ////////////////////////////////////////////////////////////

  // Major opcodes, only the integer subset
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'h13,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37
  } opcode_e;

  // funct3 of OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct7, base form and the SUB/SRA form
  localparam logic [6:0] F7_ZERO = 7'h00;
  localparam logic [6:0] F7_ALT  = 7'h20;

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // Operand B straight through, for LUI
    ALU_PASS_B
  } alu_op_e;

endpackage

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  rv_pkg::reg_addr_t  raddr_a_i,
  output rv_pkg::word_t      rdata_a_o,
  input  rv_pkg::reg_addr_t  raddr_b_i,
  output rv_pkg::word_t      rdata_b_o,

  input  logic               we_i,
  input  rv_pkg::reg_addr_t  waddr_i,
  input  rv_pkg::word_t      wdata_i
);

  import rv_pkg::*;

  // x0 has no storage
  word_t regs_q [1:NUM_REGS-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f sources.f --top-module tb_rv_core \
    --Mdir obj_dir -o sim_tb_rv_core; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/sim_tb_rv_core)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

// ==== sources.f ====
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_decode_stage.sv
logic/rv_operand_stage.sv
logic/rv_execute_stage.sv
logic/rv_core.sv
tb/tb_clock.sv
tb/tb_rv_core.sv

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Reset held for the first 3 cycles
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

  import rv_pkg::*;

  logic      clk;
  logic      rst_n;
  logic      instr_valid_i;
  word_t     instr_i;
  logic      retire_valid_o;
  reg_addr_t retire_rd_o;
  word_t     retire_data_o;
  logic      retire_illegal_o;

  // Stimulus table, one column per queue
  word_t     tab_instr[$];
  reg_addr_t tab_rd[$];
  word_t     tab_data[$];
  logic      tab_illegal[$];
  bit        tab_b2b[$];
  string     tab_name[$];

  // Instructions in flight
  int exp_idx_q[$];
  int exp_cycle_q[$];

  int          cycle_count = 0;
  int          timeout_limit = 0;
  int          pass_count = 0;
  int          fail_count = 0;
  bit          test_ok;
  int unsigned lcg_state = 1761;

  tb_clock clock_inst (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  rv_core rv_core_inst (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .instr_valid_i    (instr_valid_i),
    .instr_i          (instr_i),
    .retire_valid_o   (retire_valid_o),
    .retire_rd_o      (retire_rd_o),
    .retire_data_o    (retire_data_o),
    .retire_illegal_o (retire_illegal_o)
  );

  ////////////////////////////////////////////////////////////
  // Encoders and table
  ////////////////////////////////////////////////////////////

  function automatic word_t enc_r(input int f7, input int rs2, input int rs1,
                                  input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic word_t enc_i(input int imm12, input int rs1, input int f3, input int rd);
    return {imm12[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
  endfunction

  function automatic word_t enc_u(input int imm20, input int rd);
    return {imm20[19:0], rd[4:0], 7'h37};
  endfunction

  task automatic add_entry(input word_t instr, input int rd, input word_t data,
                           input bit illegal, input bit b2b, input string name);
    tab_instr.push_back(instr);
    tab_rd.push_back(rd[4:0]);
    tab_data.push_back(data);
    tab_illegal.push_back(illegal);
    tab_b2b.push_back(b2b);
    tab_name.push_back(name);
  endtask

  // b2b set means the next entry follows with no idle cycle
  task automatic load_table();
    add_entry(enc_i(5, 0, 0, 1),          1, 32'h0000_0005, 1'b0, 1'b1, "addi x1");
    add_entry(enc_i(7, 1, 0, 2),          2, 32'h0000_000C, 1'b0, 1'b1, "addi x2 dist1");
    add_entry(enc_r(0, 2, 1, 0, 3),       3, 32'h0000_0011, 1'b0, 1'b1, "add x3 dist1/2");
    add_entry(enc_r(32, 1, 3, 0, 4),      4, 32'h0000_000C, 1'b0, 1'b0, "sub x4 dist1/3");
    add_entry(enc_u(32'h80000, 5),        5, 32'h8000_0000, 1'b0, 1'b0, "lui x5");
    add_entry(enc_i(-1, 0, 0, 6),         6, 32'hFFFF_FFFF, 1'b0, 1'b0, "addi x6 -1");
    add_entry(enc_i(32'h404, 5, 5, 7),    7, 32'hF800_0000, 1'b0, 1'b0, "srai negative");
    add_entry(enc_i(4, 5, 5, 8),          8, 32'h0800_0000, 1'b0, 1'b0, "srli");
    add_entry(enc_i(3, 1, 1, 9),          9, 32'h0000_0028, 1'b0, 1'b0, "slli");
    add_entry(enc_i(32'hF0, 6, 4, 10),   10, 32'hFFFF_FF0F, 1'b0, 1'b0, "xori");
    add_entry(enc_i(32'h100, 1, 6, 11),  11, 32'h0000_0105, 1'b0, 1'b0, "ori");
    add_entry(enc_i(32'h7FF, 6, 7, 12),  12, 32'h0000_07FF, 1'b0, 1'b0, "andi");
    add_entry(enc_i(0, 6, 2, 13),        13, 32'h0000_0001, 1'b0, 1'b0, "slti -1 < 0");
    add_entry(enc_i(0, 6, 3, 14),        14, 32'h0000_0000, 1'b0, 1'b0, "sltiu max < 0");
    add_entry(enc_i(-1, 1, 3, 15),       15, 32'h0000_0001, 1'b0, 1'b0, "sltiu 5 < max");
    add_entry(enc_i(-16, 5, 0, 16),      16, 32'h7FFF_FFF0, 1'b0, 1'b0, "addi wrap");
    add_entry(enc_r(0, 1, 6, 2, 17),     17, 32'h0000_0001, 1'b0, 1'b0, "slt mixed sign");
    add_entry(enc_r(0, 1, 6, 3, 18),     18, 32'h0000_0000, 1'b0, 1'b0, "sltu mixed sign");
    add_entry(enc_r(32, 1, 7, 5, 19),    19, 32'hFFC0_0000, 1'b0, 1'b0, "sra");
    add_entry(enc_r(0, 1, 7, 5, 20),     20, 32'h07C0_0000, 1'b0, 1'b0, "srl");
    add_entry(enc_r(0, 1, 1, 1, 21),     21, 32'h0000_00A0, 1'b0, 1'b0, "sll");
    add_entry(enc_r(0, 3, 2, 4, 22),     22, 32'h0000_001D, 1'b0, 1'b0, "xor");
    add_entry(enc_r(0, 1, 5, 6, 23),     23, 32'h8000_0005, 1'b0, 1'b0, "or");
    add_entry(enc_r(0, 3, 6, 7, 24),     24, 32'h0000_0011, 1'b0, 1'b0, "and");
    add_entry(enc_r(32, 2, 1, 0, 25),    25, 32'hFFFF_FFF9, 1'b0, 1'b1, "sub negative");
    // x0 as destination, then read straight after
    add_entry(enc_i(9, 1, 0, 0),          0, 32'h0000_000E, 1'b0, 1'b1, "addi x0");
    add_entry(enc_r(0, 1, 0, 0, 26),     26, 32'h0000_0005, 1'b0, 1'b1, "read x0 dist1");
    add_entry(enc_i(3, 0, 0, 27),        27, 32'h0000_0003, 1'b0, 1'b0, "read x0 dist2");
    // Illegal forms, rd of x1..x4 must stay untouched
    add_entry(32'h0000_00EF,              1, 32'h0000_0000, 1'b1, 1'b1, "unknown opcode");
    add_entry(enc_r(1, 1, 1, 0, 2),       2, 32'h0000_0000, 1'b1, 1'b1, "funct7 0x01");
    add_entry(enc_i(32'h400, 1, 0, 3),    3, 32'h0000_0000, 1'b1, 1'b1, "sub immediate");
    add_entry(enc_r(32, 1, 1, 4, 4),      4, 32'h0000_0000, 1'b1, 1'b1, "xor funct7 0x20");
    add_entry(enc_r(0, 0, 1, 0, 28),     28, 32'h0000_0005, 1'b0, 1'b1, "x1 after illegal");
    add_entry(enc_r(0, 3, 2, 0, 29),     29, 32'h0000_001D, 1'b0, 1'b1, "x2+x3 after illegal");
    add_entry(enc_i(0, 4, 0, 30),        30, 32'h0000_000C, 1'b0, 1'b0, "x4 after illegal");
    add_entry(enc_i(1, 30, 0, 31),       31, 32'h0000_000D, 1'b0, 1'b0, "chain with gap 1");
    add_entry(enc_r(0, 31, 31, 0, 31),   31, 32'h0000_001A, 1'b0, 1'b0, "chain with gap 2");
    add_entry(enc_r(32, 30, 31, 0, 31),  31, 32'h0000_000E, 1'b0, 1'b0, "chain with gap 3");
  endtask

  // Idle gap of 0 to 2 cycles
  function automatic int next_gap();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'((lcg_state >> 16) % 3);
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_word(input string sig, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", sig, actual, expected);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_reg(input string sig, input reg_addr_t actual,
                           input reg_addr_t expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%02h, expected 0x%02h", sig, actual, expected);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_bit(input string sig, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", sig, actual, expected);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_retire();
    int idx;
    int strobe_cycle;
    if (exp_idx_q.size() == 0) begin
      $display("Retire strobe at cycle %0d with no instruction in flight", cycle_count);
      fail_count++;
    end else begin
      idx = exp_idx_q.pop_front();
      strobe_cycle = exp_cycle_q.pop_front();
      test_ok = 1'b1;
      check_reg("retire_rd_o", retire_rd_o, tab_rd[idx]);
      check_word("retire_data_o", retire_data_o, tab_data[idx]);
      check_bit("retire_illegal_o", retire_illegal_o, tab_illegal[idx]);
      if (cycle_count != strobe_cycle + 3) begin
        $display("Test %0d retired in cycle %0d, but its strobe was in cycle %0d",
                 idx + 1, cycle_count, strobe_cycle);
        test_ok = 1'b0;
      end
      if (test_ok) begin
        pass_count++;
        $display("Test %2d %-22s passed", idx + 1, tab_name[idx]);
      end else begin
        fail_count++;
        $display("Test %2d %-22s FAILED", idx + 1, tab_name[idx]);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Cycle count, monitor and timeout
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // Retire outputs are stable at the falling edge
  always @(negedge clk) begin
    if (retire_valid_o === 1'b1) begin
      check_retire();
    end
  end

  always @(posedge clk) begin
    if ((timeout_limit > 0) && (cycle_count >= timeout_limit)) begin
      $display("Timeout after %0d cycles with %0d instructions still in flight",
               cycle_count, exp_idx_q.size());
      $display("Something failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    int gap;
    instr_valid_i <= 1'b0;
    instr_i       <= '0;
    load_table();
    timeout_limit = tab_instr.size() * 3 + 3 + 20;

    wait (rst_n === 1'b1);
    // A few idle cycles, no retire expected here
    repeat (4) @(posedge clk);

    for (int i = 0; i < tab_instr.size(); i++) begin
      @(posedge clk);
      instr_valid_i <= 1'b1;
      instr_i       <= tab_instr[i];
      // Strobe is visible in the cycle after this edge
      exp_idx_q.push_back(i);
      exp_cycle_q.push_back(cycle_count + 1);
      gap = tab_b2b[i] ? 0 : next_gap();
      repeat (gap) begin
        @(posedge clk);
        instr_valid_i <= 1'b0;
        instr_i       <= '0;
      end
    end
    @(posedge clk);
    instr_valid_i <= 1'b0;
    instr_i       <= '0;

    while (exp_idx_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if ((fail_count == 0) && (pass_count == tab_instr.size())) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
